/* verilog.f */
src/wrot_pkg.sv
src/wrot_header_regs.sv
src/wrot_weight_mem.sv
src/wrot_loop_counters.sv
src/wrot_control.sv
src/weight_rotator.sv
tb/wrot_checker.sv
tb/tb_weight_rotator.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_weight_rotator
FILELIST  := verilog.f
VFLAGS    := --binary --assert --timescale 1ns/1ns -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := === FAIL ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --prefix V$(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_weight_rotator.sv */
// weight rotator testbench
`default_nettype none

module tb_weight_rotator;
  timeunit 1ns;
  timeprecision 1ns;

  import wrot_pkg::*;

  localparam int NUM_FRAMES  = 8;
  localparam int READY_LIMIT = 1000;
  localparam int FRAME_LIMIT = 4000;

  logic        aclk;
  logic        i_reset;
  logic        i_s_valid;
  logic        o_s_ready;
  beat_t       i_s_data;
  logic        i_s_last;
  logic        o_m_valid;
  logic        i_m_ready = 1'b0;
  beat_t       o_m_data;
  tuser_t      o_m_user;
  logic        o_m_last;
  int          errors;
  int          frames;
  int          beats;
  int          timeouts = 0;
  header_t     hdr;
  logic [31:0] rnd;

  weight_rotator dut_i (.*);

  wrot_checker checker_i (
    .aclk      (aclk),
    .i_reset   (i_reset),
    .i_s_valid (i_s_valid),
    .i_s_ready (o_s_ready),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .i_m_valid (o_m_valid),
    .i_m_ready (i_m_ready),
    .i_m_data  (o_m_data),
    .i_m_user  (o_m_user),
    .i_m_last  (o_m_last),
    .o_errors  (errors),
    .o_frames  (frames),
    .o_beats   (beats)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  // random back-pressure with ready high about 70% of cycles
  always @(negedge aclk) begin
    i_m_ready = ($urandom_range(0, 9) < 7);
  end

  task automatic send_beat(input beat_t data, input logic last);
    int   gap;
    int   waited;
    logic taken;
    gap       = $urandom_range(0, 2);
    i_s_valid = 1'b0;
    repeat (gap) @(negedge aclk);
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_last  = last;
    taken     = 1'b0;
    waited    = 0;
    while (!taken && timeouts == 0) begin
      @(posedge aclk);
      if (o_s_ready) begin
        taken = 1'b1;
      end else begin
        waited++;
        if (waited > READY_LIMIT) begin
          $display("timeout: slave stream never became ready");
          timeouts++;
        end
      end
    end
    @(negedge aclk);
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
  endtask

  task automatic send_frame(input header_t h);
    int    words;
    beat_t beat;
    words = (2 * int'(h.kh2) + 1) * (int'(h.cin_1) + 1);
    // upper bits of the header beat carry noise
    beat = {$urandom, $urandom};
    beat[$bits(header_t)-1:0] = h;
    send_beat(beat, 1'b0);
    for (int w = 0; w < words && timeouts == 0; w++) begin
      send_beat({$urandom, $urandom}, w == words - 1);
    end
  endtask

  task automatic wait_frames(input int target);
    int waited;
    waited = 0;
    while (frames < target && timeouts == 0) begin
      @(negedge aclk);
      waited++;
      if (waited > FRAME_LIMIT) begin
        $display("timeout: replay of frame %0d did not finish", target - 1);
        timeouts++;
      end
    end
  endtask

  initial begin
    rnd       = $urandom(32'h9b0a_b699);
    i_reset   = 1'b1;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    i_reset = 1'b0;
    for (int f = 0; f < NUM_FRAMES && timeouts == 0; f++) begin
      rnd = $urandom;
      // frame 0 at minimum sizes and frame 1 at maximum
      if (f == 0) hdr = '0;
      else if (f == 1) hdr = '1;
      else hdr = rnd[$bits(header_t)-1:0];
      send_frame(hdr);
      wait_frames(f + 1);
    end
    repeat (4) @(negedge aclk);
    $display("beats %0d, frames %0d of %0d, errors %0d, timeouts %0d",
             beats, frames, NUM_FRAMES, errors, timeouts);
    if (errors == 0 && timeouts == 0 && frames == NUM_FRAMES) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/wrot_checker.sv */
// replay monitor and scoreboard
`default_nettype none

module wrot_checker (
  input  wire logic             aclk,
  input  wire logic             i_reset,
  input  wire logic             i_s_valid,
  input  wire logic             i_s_ready,
  input  wire wrot_pkg::beat_t  i_s_data,
  input  wire logic             i_s_last,
  input  wire logic             i_m_valid,
  input  wire logic             i_m_ready,
  input  wire wrot_pkg::beat_t  i_m_data,
  input  wire wrot_pkg::tuser_t i_m_user,
  input  wire logic             i_m_last,
  output int                    o_errors,
  output int                    o_frames,
  output int                    o_beats
);
  timeunit 1ns;
  timeprecision 1ns;

  import wrot_pkg::*;

  typedef struct packed {
    beat_t  data;
    tuser_t user;
    logic   last;
  } m_beat_t;

  header_t cap_hdr;
  header_t rep_hdr;
  beat_t   cap_words [DEPTH];
  beat_t   rep_words [DEPTH];
  m_beat_t exp_beat;
  m_beat_t held;
  logic    hdr_seen    = 1'b0;
  logic    active      = 1'b0;
  logic    hold        = 1'b0;
  int      cap_idx     = 0;
  int      beat_idx    = 0;
  int      idle_cycles = 0;
  int      errors      = 0;
  int      frames      = 0;
  int      beats       = 0;

  assign o_errors = errors;
  assign o_frames = frames;
  assign o_beats  = beats;

  // beat n of a replay worked out from the header fields
  function automatic m_beat_t ref_beat(input header_t h, input int n);
    int      per;
    int      cols;
    int      blocks;
    int      coli;
    m_beat_t e;
    per    = (2 * int'(h.kh2) + 1) * (int'(h.cin_1) + 1);
    cols   = int'(h.cols_1) + 1;
    blocks = int'(h.blocks_1) + 1;
    coli   = (n / per) % cols;
    e.data                 = rep_words[addr_t'(n % per)];
    e.user.kw2             = h.kw2;
    e.user.is_w_first      = (n % (per * cols) == 0);
    e.user.is_cin_last     = (n % per == per - 1);
    e.user.is_cols_1_k2    = (cols - 1 - coli == int'(h.kw2));
    e.user.is_top_block    = (n / (per * cols) == 0);
    e.user.is_bottom_block = (n / (per * cols) == blocks - 1);
    e.last                 = (n == per * cols * blocks - 1);
    return e;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("FAILED %s (frame %0d beat %0d): expected %h, actual %h",
               name, frames, beat_idx, exp, act);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  always @(posedge aclk) begin
    if (i_reset) begin
      hdr_seen    = 1'b0;
      active      = 1'b0;
      hold        = 1'b0;
      idle_cycles = 0;
    end else begin
      // both streams idle only briefly before the next header
      if (!i_s_ready && !i_m_valid) begin
        idle_cycles++;
        if (idle_cycles == 3) report_error("o_s_ready did not rise within 2 cycles");
      end else begin
        idle_cycles = 0;
      end
      if (i_s_ready && active) report_error("slave side ready while a replay is running");
      if (!active && (i_m_valid || i_m_last)) begin
        report_error("master stream active outside a replay");
      end
      // a stalled beat holds until it is taken
      if (hold) begin
        if (!i_m_valid) report_error("o_m_valid dropped before the handshake");
        check_value("stable_data", held.data, i_m_data);
        check_value("stable_user", 64'(held.user), 64'(i_m_user));
        check_value("stable_last", 64'(held.last), 64'(i_m_last));
      end
      if (i_m_valid && i_m_ready && active) begin
        exp_beat = ref_beat(rep_hdr, beat_idx);
        check_value("replay_data", exp_beat.data, i_m_data);
        check_value("replay_user", 64'(exp_beat.user), 64'(i_m_user));
        check_value("replay_last", 64'(exp_beat.last), 64'(i_m_last));
        beat_idx++;
        beats++;
        if (i_m_last || exp_beat.last) begin
          active = 1'b0;
          frames++;
        end
      end
      hold = i_m_valid && !i_m_ready;
      held = {i_m_data, i_m_user, i_m_last};
      // header first, then the weights up to i_s_last
      if (i_s_valid && i_s_ready) begin
        if (!hdr_seen) begin
          cap_hdr  = i_s_data[$bits(header_t)-1:0];
          cap_idx  = 0;
          hdr_seen = 1'b1;
        end else begin
          if (cap_idx < DEPTH) cap_words[addr_t'(cap_idx)] = i_s_data;
          cap_idx++;
          if (i_s_last) begin
            rep_hdr   = cap_hdr;
            rep_words = cap_words;
            beat_idx  = 0;
            active    = 1'b1;
            hdr_seen  = 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/weight_rotator.sv */
// weight rotator top level
`default_nettype none

module weight_rotator (
  input  wire logic             aclk,
  input  wire logic             i_reset,
  input  wire logic             i_s_valid,
  output      logic             o_s_ready,
  input  wire wrot_pkg::beat_t  i_s_data,
  input  wire logic             i_s_last,
  output      logic             o_m_valid,
  input  wire logic             i_m_ready,
  output      wrot_pkg::beat_t  o_m_data,
  output      wrot_pkg::tuser_t o_m_user,
  output      logic             o_m_last
);

  import wrot_pkg::*;

  logic    load_hdr;
  logic    wr_en;
  logic    rd_start;
  logic    rd_adv;
  logic    frame_done;
  header_t s_hdr;
  header_t hdr;
  addr_t   addr_max;

  // header fields sit in the low bits of the first beat
  assign s_hdr = header_t'(i_s_data[$bits(header_t)-1:0]);

  wrot_control control_i (
    .aclk         (aclk),
    .i_reset      (i_reset),
    .i_s_valid    (i_s_valid),
    .i_s_last     (i_s_last),
    .i_m_ready    (i_m_ready),
    .i_frame_done (frame_done),
    .o_s_ready    (o_s_ready),
    .o_m_valid    (o_m_valid),
    .o_load_hdr   (load_hdr),
    .o_wr_en      (wr_en),
    .o_rd_start   (rd_start),
    .o_rd_adv     (rd_adv)
  );

  wrot_header_regs header_regs_i (
    .aclk       (aclk),
    .i_reset    (i_reset),
    .i_load     (load_hdr),
    .i_hdr      (s_hdr),
    .o_hdr      (hdr),
    .o_addr_max (addr_max)
  );

  wrot_weight_mem weight_mem_i (
    .aclk       (aclk),
    .i_reset    (i_reset),
    .i_wr_en    (wr_en),
    .i_wr_data  (i_s_data),
    .i_rd_start (rd_start),
    .i_rd_adv   (rd_adv),
    .i_addr_max (addr_max),
    .o_rd_data  (o_m_data)
  );

  wrot_loop_counters loop_counters_i (
    .aclk         (aclk),
    .i_reset      (i_reset),
    .i_start      (rd_start),
    .i_adv        (rd_adv),
    .i_hdr        (hdr),
    .o_user       (o_m_user),
    .o_last       (o_m_last),
    .o_frame_done (frame_done)
  );

endmodule

`default_nettype wire

/* src/wrot_control.sv */
// write and read state machines
`default_nettype none

module wrot_control (
  input  wire logic aclk,
  input  wire logic i_reset,
  input  wire logic i_s_valid,
  input  wire logic i_s_last,
  input  wire logic i_m_ready,
  input  wire logic i_frame_done,
  output      logic o_s_ready,
  output      logic o_m_valid,
  output      logic o_load_hdr,
  output      logic o_wr_en,
  output      logic o_rd_start,
  output      logic o_rd_adv
);

  import wrot_pkg::*;

  w_state_t w_state;
  w_state_t w_state_next;
  r_state_t r_state;
  r_state_t r_state_next;

  // slave side open only while filling the store
  assign o_s_ready  = (w_state == W_GET_REF) || (w_state == W_WRITE);
  assign o_m_valid  = (r_state == R_READ);
  assign o_load_hdr = (w_state == W_GET_REF) && i_s_valid;
  assign o_wr_en    = (w_state == W_WRITE) && i_s_valid;
  assign o_rd_start = o_wr_en && i_s_last;
  assign o_rd_adv   = o_m_valid && i_m_ready;

  always_comb begin
    w_state_next = w_state;
    case (w_state)
      // single bank, so wait for the replay to finish
      W_IDLE:    if (r_state == R_IDLE) w_state_next = W_GET_REF;
      W_GET_REF: if (o_load_hdr) w_state_next = W_WRITE;
      W_WRITE:   if (o_rd_start) w_state_next = W_IDLE;
      default:   w_state_next = W_IDLE;
    endcase
  end

  always_comb begin
    r_state_next = r_state;
    case (r_state)
      R_IDLE:  if (o_rd_start) r_state_next = R_READ;
      R_READ:  if (i_frame_done) r_state_next = R_IDLE;
      default: r_state_next = R_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      w_state <= W_IDLE;
      r_state <= R_IDLE;
    end else begin
      w_state <= w_state_next;
      r_state <= r_state_next;
    end
  end

  // fill and replay never overlap
  a_excl_streams : assert property (
    @(posedge aclk) disable iff (i_reset)
    !(o_s_ready && o_m_valid)
  );

endmodule

`default_nettype wire

/* src/wrot_loop_counters.sv */
// nested replay counters and user flags
`default_nettype none

module wrot_loop_counters (
  input  wire logic              aclk,
  input  wire logic              i_reset,
  input  wire logic              i_start,
  input  wire logic              i_adv,
  input  wire wrot_pkg::header_t i_hdr,
  output      wrot_pkg::tuser_t  o_user,
  output      logic              o_last,
  output      logic              o_frame_done
);

  import wrot_pkg::*;

  kh_cnt_t cnt_kh;
  cin_t    cnt_cin;
  cols_t   cnt_cols;
  blocks_t cnt_blocks;
  kh_cnt_t kh_start;
  logic    running;
  logic    kh_zero;
  logic    cin_zero;
  logic    cols_zero;
  logic    blocks_zero;

  // kh counts 2*kh2 down to 0
  assign kh_start    = {i_hdr.kh2, 1'b0};
  assign kh_zero     = (cnt_kh == '0);
  assign cin_zero    = (cnt_cin == '0);
  assign cols_zero   = (cnt_cols == '0);
  assign blocks_zero = (cnt_blocks == '0);

  // kh -> cin -> cols -> blocks with a reload on each wrap
  always_ff @(posedge aclk) begin
    if (i_reset) begin
      cnt_kh     <= '0;
      cnt_cin    <= '0;
      cnt_cols   <= '0;
      cnt_blocks <= '0;
    end else if (i_start) begin
      cnt_kh     <= kh_start;
      cnt_cin    <= i_hdr.cin_1;
      cnt_cols   <= i_hdr.cols_1;
      cnt_blocks <= i_hdr.blocks_1;
    end else if (i_adv) begin
      cnt_kh <= kh_zero ? kh_start : cnt_kh - kh_cnt_t'(1);
      if (kh_zero) begin
        cnt_cin <= cin_zero ? i_hdr.cin_1 : cnt_cin - cin_t'(1);
      end
      if (kh_zero && cin_zero) begin
        cnt_cols <= cols_zero ? i_hdr.cols_1 : cnt_cols - cols_t'(1);
      end
      if (kh_zero && cin_zero && cols_zero) begin
        cnt_blocks <= blocks_zero ? i_hdr.blocks_1 : cnt_blocks - blocks_t'(1);
      end
    end
  end

  // keeps last low while the counters idle at zero
  always_ff @(posedge aclk) begin
    if (i_reset) begin
      running <= 1'b0;
    end else if (i_start) begin
      running <= 1'b1;
    end else if (o_frame_done) begin
      running <= 1'b0;
    end
  end

  assign o_last       = running && kh_zero && cin_zero && cols_zero && blocks_zero;
  assign o_frame_done = i_adv && o_last;

  always_comb begin
    o_user.kw2             = i_hdr.kw2;
    o_user.is_w_first      = (cnt_cols == i_hdr.cols_1) && (cnt_cin == i_hdr.cin_1) &&
                             (cnt_kh == kh_start);
    o_user.is_cin_last     = kh_zero && cin_zero;
    // column index equals cols-1-kw2
    o_user.is_cols_1_k2    = (cnt_cols == cols_t'(i_hdr.kw2));
    o_user.is_top_block    = (cnt_blocks == i_hdr.blocks_1);
    o_user.is_bottom_block = blocks_zero;
  end

endmodule

`default_nettype wire

/* src/wrot_weight_mem.sv */
// cyclic weight store
`default_nettype none

module wrot_weight_mem (
  input  wire logic            aclk,
  input  wire logic            i_reset,
  input  wire logic            i_wr_en,
  input  wire wrot_pkg::beat_t i_wr_data,
  input  wire logic            i_rd_start,
  input  wire logic            i_rd_adv,
  input  wire wrot_pkg::addr_t i_addr_max,
  output      wrot_pkg::beat_t o_rd_data
);

  import wrot_pkg::*;

  beat_t mem [DEPTH];
  addr_t wr_ptr;
  addr_t rd_ptr;

  // weights in arrival order
  always_ff @(posedge aclk) begin
    if (i_wr_en) begin
      mem[wr_ptr] <= i_wr_data;
    end
  end

  // sequential fill that rewinds once the frame is complete
  always_ff @(posedge aclk) begin
    if (i_reset || i_rd_start) begin
      wr_ptr <= '0;
    end else if (i_wr_en) begin
      wr_ptr <= wr_ptr + addr_t'(1);
    end
  end

  // wrap at the last word gives the rotation
  always_ff @(posedge aclk) begin
    if (i_reset || i_rd_start) begin
      rd_ptr <= '0;
    end else if (i_rd_adv) begin
      if (rd_ptr == i_addr_max) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + addr_t'(1);
      end
    end
  end

  // zero latency read
  assign o_rd_data = mem[rd_ptr];

  // input frames never exceed the store
  a_no_overflow : assert property (
    @(posedge aclk) disable iff (i_reset)
    i_wr_en |-> (wr_ptr <= addr_t'(DEPTH - 1))
  );

endmodule

`default_nettype wire

/* src/wrot_header_regs.sv */
// header reference registers
`default_nettype none

module wrot_header_regs (
  input  wire logic             aclk,
  input  wire logic             i_reset,
  input  wire logic             i_load,
  input  wire wrot_pkg::header_t i_hdr,
  output      wrot_pkg::header_t o_hdr,
  output      wrot_pkg::addr_t   o_addr_max
);

  import wrot_pkg::*;

  kh_cnt_t    kh;
  logic [3:0] cin_cnt;
  addr_t      words;
  addr_t      addr_max_next;

  // kh = 2*kh2+1, so it is either 1 or 3
  always_comb begin
    kh            = {i_hdr.kh2, 1'b1};
    cin_cnt       = {1'b0, i_hdr.cin_1} + 4'd1;
    words         = addr_t'({3'b000, kh} * {1'b0, cin_cnt});
    addr_max_next = words - addr_t'(1);
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      o_hdr      <= '0;
      o_addr_max <= '0;
    end else if (i_load) begin
      o_hdr      <= i_hdr;
      // index of the last stored word
      o_addr_max <= addr_max_next;
    end
  end

endmodule

`default_nettype wire

/* src/wrot_pkg.sv */
// weight rotator shared definitions
`default_nettype none

package wrot_pkg;

  // beat geometry
  localparam int WORD_W  = 8;
  localparam int CORES   = 2;
  localparam int MEMBERS = 4;
  localparam int M_W     = WORD_W * CORES * MEMBERS;

  // largest frame the store can hold
  localparam int KH_MAX     = 3;
  localparam int CIN_MAX    = 8;
  localparam int COLS_MAX   = 4;
  localparam int BLOCKS_MAX = 4;
  localparam int DEPTH      = KH_MAX * CIN_MAX;
  localparam int ADDR_W     = $clog2(DEPTH);

  typedef logic [M_W-1:0]    beat_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic              kw2_t;
  typedef logic              kh2_t;
  typedef logic [1:0]        kh_cnt_t;
  typedef logic [2:0]        cin_t;
  typedef logic [1:0]        cols_t;
  typedef logic [1:0]        blocks_t;

  // low bits of the header beat
  typedef struct packed {
    blocks_t blocks_1;
    cols_t   cols_1;
    cin_t    cin_1;
    kh2_t    kh2;
    kw2_t    kw2;
  } header_t;

  // position flags sent with every master beat
  typedef struct packed {
    kw2_t kw2;
    logic is_w_first;
    logic is_cin_last;
    logic is_cols_1_k2;
    logic is_top_block;
    logic is_bottom_block;
  } tuser_t;

  typedef enum logic [1:0] {W_IDLE, W_GET_REF, W_WRITE} w_state_t;
  typedef enum logic {R_IDLE, R_READ} r_state_t;

endpackage

`default_nettype wire
